// ==== project.f ====
+incdir+include
logic/db_pkg.sv
logic/db_ctx_fifo.sv
logic/db_table_bank.sv
logic/db_prio_mux.sv
logic/db_rr_demux.sv
logic/db_query_fabric.sv
dv/db_query_fabric_tb.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f \
    --top-module db_query_fabric_tb -o sim_db_query_fabric
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_db_query_fabric > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    exit 1
fi
exit 0

// ==== dv/db_query_fabric_tb.sv ====
`timescale 1ns/1ps

`include "db_defines.svh"

module db_query_fabric_tb;
    import db_pkg::*;

    localparam int HI          = 0;
    localparam int LO          = 1;
    localparam int LAT         = `DB_BANK_LAT;
    localparam int NUM_KEYS    = 2 ** `DB_KEY_WID;
    localparam int REQ_TIMEOUT = 32;
    localparam int MODE_SWEEP  = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_ALT    = 2;
    localparam int MODE_IDLE   = 3;

    // Expected response and the edge on which its ack is sampled
    typedef struct packed {
        int        due;
        db_key_t   key;
        logic      valid;
        db_value_t value;
    } exp_t;

    logic          clk;
    logic          i_rst_n;
    db_query_req_t i_hi_req;
    logic          o_hi_rdy;
    db_query_rsp_t o_hi_rsp;
    db_query_req_t i_lo_req;
    logic          o_lo_rdy;
    db_query_rsp_t o_lo_rsp;
    db_update_t    i_upd;

    integer    seed;
    int        cyc = 0;
    int        mismatch_count = 0;
    int        timeout_count = 0;
    int        other_count = 0;
    int        sweep_next [2];
    logic      pend [2];
    db_key_t   key_hold [2];
    int        wait_cnt [2];
    logic      model_valid [NUM_KEYS];
    db_value_t model_value [NUM_KEYS];
    exp_t      hi_q [$];
    exp_t      lo_q [$];

    db_query_fabric dut0 (
        .clk      ( clk ),
        .i_rst_n  ( i_rst_n ),
        .i_hi_req ( i_hi_req ),
        .o_hi_rdy ( o_hi_rdy ),
        .o_hi_rsp ( o_hi_rsp ),
        .i_lo_req ( i_lo_req ),
        .o_lo_rdy ( o_lo_rdy ),
        .o_lo_rsp ( o_lo_rsp ),
        .i_upd    ( i_upd )
    );

    always #4 clk = ~clk;

    // Rising edge count used to time each ack against its acceptance
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic compare_value(input string what, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s, got %0h expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    function automatic exp_t expected_lookup(input db_key_t key, input int due);
        exp_t e;
        e.due   = due;
        e.key   = key;
        e.valid = model_valid[key];
        e.value = model_value[key];
        return e;
    endfunction

    // Ack seen here is sampled on the coming edge cyc + 1
    task automatic check_port_ack(input int port, input db_query_rsp_t rsp);
        string name;
        exp_t  head;
        int    pending;
        name    = (port == HI) ? "hi" : "lo";
        pending = (port == HI) ? hi_q.size() : lo_q.size();
        if (pending > 0) begin
            head = (port == HI) ? hi_q[0] : lo_q[0];
        end
        if (rsp.ack && pending == 0) begin
            other_count++;
            $display("Error at %0t ns: ack on %s port with no query open", $time, name);
        end else if (rsp.ack) begin
            compare_value($sformatf("%s ack cycle, key %0d", name, head.key),
                          cyc + 1, head.due);
            compare_value($sformatf("%s valid, key %0d", name, head.key),
                          rsp.valid, head.valid);
            if (head.valid) begin
                compare_value($sformatf("%s value, key %0d", name, head.key),
                              rsp.value, head.value);
            end
        end else if (pending > 0 && head.due <= cyc + 1) begin
            timeout_count++;
            $display("Error at %0t ns: no ack on %s port for key %0d by its cycle",
                     $time, name, head.key);
        end
        if (pending > 0 && (rsp.ack || head.due <= cyc + 1)) begin
            if (port == HI) begin
                void'(hi_q.pop_front());
            end else begin
                void'(lo_q.pop_front());
            end
        end
    endtask

    task automatic drive_stimulus(input int mode);
        int r;
        for (int p = 0; p < 2; p++) begin
            r = $random(seed) & 3;
            // Hi leaves every other cycle free so the lo sweep is not starved
            if (!pend[p] && mode == MODE_SWEEP && sweep_next[p] < NUM_KEYS
                    && (p == LO || cyc % 2 == 0)) begin
                pend[p]     = 1'b1;
                key_hold[p] = db_key_t'(sweep_next[p]);
                sweep_next[p]++;
            end else if (!pend[p] && mode == MODE_RANDOM) begin
                // Lo asks more often so it still finds gaps between hi requests
                pend[p]     = (p == HI) ? (r < 2) : (r != 0);
                key_hold[p] = db_key_t'($random(seed));
            end else if (!pend[p] && mode == MODE_ALT) begin
                // Hi on even cycles with lo always waiting so grants interleave
                pend[p]     = (p == LO) || (cyc % 2 == 0);
                key_hold[p] = db_key_t'($random(seed));
            end
        end
        i_upd = '0;
        r = $random(seed) & 7;
        if ((mode == MODE_RANDOM || mode == MODE_ALT) && r < 3) begin
            i_upd.wr    = 1'b1;
            i_upd.key   = db_key_t'($random(seed));
            i_upd.valid = (($random(seed) & 3) != 0);
            i_upd.value = db_value_t'($random(seed));
            // Aim at a waiting query now and then to hit read before write
            if (r == 0 && pend[HI]) begin
                i_upd.key = key_hold[HI];
            end
            if (r == 1 && pend[LO]) begin
                i_upd.key = key_hold[LO];
            end
        end
        i_hi_req.req = pend[HI];
        i_hi_req.key = key_hold[HI];
        i_lo_req.req = pend[LO];
        i_lo_req.key = key_hold[LO];
    endtask

    task automatic track_wait(input int port, input logic accepted);
        if (accepted) begin
            pend[port]     = 1'b0;
            wait_cnt[port] = 0;
        end else if (pend[port]) begin
            wait_cnt[port]++;
            if (wait_cnt[port] > REQ_TIMEOUT) begin
                timeout_count++;
                $display("Error at %0t ns: %s request not accepted within %0d cycles",
                         $time, (port == HI) ? "hi" : "lo", REQ_TIMEOUT);
                pend[port]     = 1'b0;
                wait_cnt[port] = 0;
            end
        end
    endtask

    // Inputs are settled here and hold until the next rising edge
    task automatic sample_accepts();
        logic hi_acc;
        logic lo_acc;
        hi_acc = i_hi_req.req && o_hi_rdy;
        lo_acc = i_lo_req.req && o_lo_rdy;
        if (i_hi_req.req && o_lo_rdy) begin
            other_count++;
            $display("Error at %0t ns: lo rdy is high while hi requests", $time);
        end
        if (hi_acc) begin
            hi_q.push_back(expected_lookup(i_hi_req.key, cyc + 1 + LAT));
        end
        if (lo_acc) begin
            lo_q.push_back(expected_lookup(i_lo_req.key, cyc + 1 + LAT));
        end
        track_wait(HI, hi_acc);
        track_wait(LO, lo_acc);
        // Table write on the same edge lands after the lookups above
        if (i_upd.wr) begin
            model_valid[i_upd.key] = i_upd.valid;
            model_value[i_upd.key] = i_upd.value;
        end
    endtask

    task automatic step(input int mode);
        @(negedge clk);
        check_port_ack(HI, o_hi_rsp);
        check_port_ack(LO, o_lo_rsp);
        drive_stimulus(mode);
        #1;
        sample_accepts();
    endtask

    initial begin
        int n;
        clk      = 1'b0;
        i_rst_n  = 1'b0;
        i_hi_req = '0;
        i_lo_req = '0;
        i_upd    = '0;
        seed     = 25;
        for (int p = 0; p < 2; p++) begin
            sweep_next[p] = 0;
            pend[p]       = 1'b0;
            key_hold[p]   = '0;
            wait_cnt[p]   = 0;
        end
        for (int k = 0; k < NUM_KEYS; k++) begin
            model_valid[k] = 1'b0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        n = 0;
        while (!(o_hi_rdy && o_lo_rdy) && n < REQ_TIMEOUT) begin
            @(negedge clk);
            compare_value("hi ack after reset", o_hi_rsp.ack, 0);
            compare_value("lo ack after reset", o_lo_rsp.ack, 0);
            n++;
        end
        if (!(o_hi_rdy && o_lo_rdy)) begin
            timeout_count++;
            $display("Error at %0t ns: rdy did not come up after reset", $time);
        end

        // Every key on both ports misses before any update
        n = 0;
        while ((sweep_next[HI] < NUM_KEYS || sweep_next[LO] < NUM_KEYS) && n < 4 * NUM_KEYS) begin
            step(MODE_SWEEP);
            n++;
        end
        if (sweep_next[HI] < NUM_KEYS || sweep_next[LO] < NUM_KEYS) begin
            timeout_count++;
            $display("Error at %0t ns: key sweep did not finish", $time);
        end

        repeat (1500) step(MODE_RANDOM);
        repeat (300) step(MODE_ALT);

        n = 0;
        while ((hi_q.size() > 0 || lo_q.size() > 0 || pend[HI] || pend[LO]) && n < 20) begin
            step(MODE_IDLE);
            n++;
        end
        if (hi_q.size() > 0 || lo_q.size() > 0) begin
            timeout_count++;
            $display("Error at %0t ns: queries still open after drain", $time);
        end

        $display("Errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatch_count, timeout_count, other_count);
        if (mismatch_count + timeout_count + other_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : db_query_fabric_tb

// ==== logic/db_query_fabric.sv ====
`timescale 1ns/1ps

module db_query_fabric (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  db_pkg::db_query_req_t i_hi_req,
    output logic                  o_hi_rdy,
    output db_pkg::db_query_rsp_t o_hi_rsp,
    input  db_pkg::db_query_req_t i_lo_req,
    output logic                  o_lo_rdy,
    output db_pkg::db_query_rsp_t o_lo_rsp,
    input  db_pkg::db_update_t    i_upd
);
    import db_pkg::*;

    // Merged stream between mux and demux
    db_query_req_t mux_req;
    logic          mux_rdy;
    db_query_rsp_t mux_rsp;

    // Per-bank links
    db_query_req_t bank0_req;
    logic          bank0_rdy;
    db_query_rsp_t bank0_rsp;
    db_query_req_t bank1_req;
    logic          bank1_rdy;
    db_query_rsp_t bank1_rsp;

    db_prio_mux mux0 (
        .clk      ( clk ),
        .i_rst_n  ( i_rst_n ),
        .i_hi_req ( i_hi_req ),
        .o_hi_rdy ( o_hi_rdy ),
        .o_hi_rsp ( o_hi_rsp ),
        .i_lo_req ( i_lo_req ),
        .o_lo_rdy ( o_lo_rdy ),
        .o_lo_rsp ( o_lo_rsp ),
        .o_req    ( mux_req ),
        .i_rdy    ( mux_rdy ),
        .i_rsp    ( mux_rsp )
    );

    db_rr_demux demux0 (
        .clk         ( clk ),
        .i_rst_n     ( i_rst_n ),
        .i_req       ( mux_req ),
        .o_rdy       ( mux_rdy ),
        .o_rsp       ( mux_rsp ),
        .o_bank0_req ( bank0_req ),
        .i_bank0_rdy ( bank0_rdy ),
        .i_bank0_rsp ( bank0_rsp ),
        .o_bank1_req ( bank1_req ),
        .i_bank1_rdy ( bank1_rdy ),
        .i_bank1_rsp ( bank1_rsp )
    );

    // Both replicas take every update so their contents never diverge
    db_table_bank bank0 (
        .clk     ( clk ),
        .i_rst_n ( i_rst_n ),
        .i_req   ( bank0_req ),
        .o_rdy   ( bank0_rdy ),
        .o_rsp   ( bank0_rsp ),
        .i_upd   ( i_upd )
    );

    db_table_bank bank1 (
        .clk     ( clk ),
        .i_rst_n ( i_rst_n ),
        .i_req   ( bank1_req ),
        .o_rdy   ( bank1_rdy ),
        .o_rsp   ( bank1_rsp ),
        .i_upd   ( i_upd )
    );

endmodule : db_query_fabric

// ==== logic/db_rr_demux.sv ====
`timescale 1ns/1ps

module db_rr_demux (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  db_pkg::db_query_req_t i_req,
    output logic                  o_rdy,
    output db_pkg::db_query_rsp_t o_rsp,
    output db_pkg::db_query_req_t o_bank0_req,
    input  logic                  i_bank0_rdy,
    input  db_pkg::db_query_rsp_t i_bank0_rsp,
    output db_pkg::db_query_req_t o_bank1_req,
    input  logic                  i_bank1_rdy,
    input  db_pkg::db_query_rsp_t i_bank1_rsp
);
    import db_pkg::*;

    db_bank_sel_t target;
    db_bank_sel_t head_bank;
    logic         ctx_full;
    logic         target_rdy;
    logic         fwd_req;
    logic         accept;

    assign target_rdy = (target == DB_BANK0) ? i_bank0_rdy : i_bank1_rdy;
    assign o_rdy      = target_rdy && !ctx_full;
    assign fwd_req    = i_req.req && !ctx_full;
    assign accept     = i_req.req && o_rdy;

    // Key goes to both banks, only the target sees req
    always_comb begin
        o_bank0_req     = i_req;
        o_bank1_req     = i_req;
        o_bank0_req.req = fwd_req && (target == DB_BANK0);
        o_bank1_req.req = fwd_req && (target == DB_BANK1);
    end

    // Round-robin pointer, moves on each accepted request
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            target <= DB_BANK0;
        end else if (accept) begin
            target <= (target == DB_BANK0) ? DB_BANK1 : DB_BANK0;
        end
    end

    db_ctx_fifo #(
        .ctx_t ( db_bank_sel_t )
    ) ctx_fifo0 (
        .clk         ( clk ),
        .i_rst_n     ( i_rst_n ),
        .i_push      ( accept ),
        .i_push_data ( target ),
        .i_pop       ( o_rsp.ack ),
        .o_head      ( head_bank ),
        .o_full      ( ctx_full )
    );

    // Collect from the bank holding the oldest open query
    assign o_rsp = (head_bank == DB_BANK0) ? i_bank0_rsp : i_bank1_rsp;

endmodule : db_rr_demux

// ==== logic/db_prio_mux.sv ====
`timescale 1ns/1ps

module db_prio_mux (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  db_pkg::db_query_req_t i_hi_req,
    output logic                  o_hi_rdy,
    output db_pkg::db_query_rsp_t o_hi_rsp,
    input  db_pkg::db_query_req_t i_lo_req,
    output logic                  o_lo_rdy,
    output db_pkg::db_query_rsp_t o_lo_rsp,
    output db_pkg::db_query_req_t o_req,
    input  logic                  i_rdy,
    input  db_pkg::db_query_rsp_t i_rsp
);
    import db_pkg::*;

    db_src_sel_t sel;
    db_src_sel_t owner;
    logic        ctx_full;
    logic        fwd_rdy;
    logic        accept;

    // Hi wins whenever it is requesting
    assign sel = i_hi_req.req ? DB_SRC_HI : DB_SRC_LO;

    // No room to record the owner means nothing can be accepted
    assign fwd_rdy  = i_rdy && !ctx_full;
    assign o_hi_rdy = fwd_rdy;
    assign o_lo_rdy = fwd_rdy && !i_hi_req.req;

    always_comb begin
        o_req     = (sel == DB_SRC_HI) ? i_hi_req : i_lo_req;
        o_req.req = o_req.req && !ctx_full;
    end

    assign accept = o_req.req && i_rdy;

    db_ctx_fifo #(
        .ctx_t ( db_src_sel_t )
    ) ctx_fifo0 (
        .clk         ( clk ),
        .i_rst_n     ( i_rst_n ),
        .i_push      ( accept ),
        .i_push_data ( sel ),
        .i_pop       ( i_rsp.ack ),
        .o_head      ( owner ),
        .o_full      ( ctx_full )
    );

    // Responses go to the owner of the oldest open transaction only
    always_comb begin
        o_hi_rsp = '0;
        o_lo_rsp = '0;
        if (owner == DB_SRC_HI) begin
            o_hi_rsp = i_rsp;
        end else begin
            o_lo_rsp = i_rsp;
        end
    end

endmodule : db_prio_mux

// ==== logic/db_table_bank.sv ====
`timescale 1ns/1ps

`include "db_defines.svh"

module db_table_bank (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  db_pkg::db_query_req_t i_req,
    output logic                  o_rdy,
    output db_pkg::db_query_rsp_t o_rsp,
    input  db_pkg::db_update_t    i_upd
);
    import db_pkg::*;

    localparam int NUM_ENTRIES = 2 ** `DB_KEY_WID;
    localparam int LAT         = `DB_BANK_LAT;

    logic           entry_valid [NUM_ENTRIES];
    db_value_t      entry_value [NUM_ENTRIES];
    logic           rdy_q;
    logic           accept;
    logic [LAT-1:0] ack_pipe;
    logic           hit_pipe [LAT];
    db_value_t      val_pipe [LAT];

    // Comes up one cycle after reset and stays up
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rdy_q <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
        end
    end

    assign o_rdy  = rdy_q;
    assign accept = i_req.req && rdy_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entry_valid[i] <= 1'b0;
            end
        end else if (i_upd.wr) begin
            entry_valid[i_upd.key] <= i_upd.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_upd.wr) begin
            entry_value[i_upd.key] <= i_upd.value;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            ack_pipe <= '0;
        end else begin
            ack_pipe[0] <= accept;
            for (int i = 1; i < LAT; i++) begin
                ack_pipe[i] <= ack_pipe[i-1];
            end
        end
    end

    // Stage 0 samples the old contents, an update on the same edge lands after
    always_ff @(posedge clk) begin
        hit_pipe[0] <= entry_valid[i_req.key];
        val_pipe[0] <= entry_valid[i_req.key] ? entry_value[i_req.key] : '0;
        for (int i = 1; i < LAT; i++) begin
            hit_pipe[i] <= hit_pipe[i-1];
            val_pipe[i] <= val_pipe[i-1];
        end
    end

    always_comb begin
        o_rsp.ack   = ack_pipe[LAT-1];
        o_rsp.valid = hit_pipe[LAT-1];
        o_rsp.value = val_pipe[LAT-1];
    end

endmodule : db_table_bank

// ==== logic/db_ctx_fifo.sv ====
`timescale 1ns/1ps

`include "db_defines.svh"

module db_ctx_fifo #(
    parameter type ctx_t = logic
) (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_push,
    input  ctx_t i_push_data,
    input  logic i_pop,
    output ctx_t o_head,
    output logic o_full
);
    localparam int DEPTH   = `DB_CTX_DEPTH;
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    ctx_t               mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign o_full  = (count == CNT_WID'(DEPTH));
    // Guard against overflow and underflow
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && (count != '0);
    assign o_head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : db_ctx_fifo

// ==== logic/db_pkg.sv ====
`include "db_defines.svh"

package db_pkg;

    typedef logic [`DB_KEY_WID-1:0]   db_key_t;
    typedef logic [`DB_VALUE_WID-1:0] db_value_t;

    // Lookup request, held until accepted with rdy
    typedef struct packed {
        logic    req;
        db_key_t key;
    } db_query_req_t;

    // Lookup response, ack is a single-cycle strobe
    typedef struct packed {
        logic      ack;
        logic      valid;
        db_value_t value;
    } db_query_rsp_t;

    // Table write, valid low removes the entry
    typedef struct packed {
        logic      wr;
        db_key_t   key;
        logic      valid;
        db_value_t value;
    } db_update_t;

    // Owner of a transaction in the priority mux
    typedef enum logic {
        DB_SRC_HI = 1'b0,
        DB_SRC_LO = 1'b1
    } db_src_sel_t;

    // Bank that holds a transaction in the round-robin demux
    typedef enum logic {
        DB_BANK0 = 1'b0,
        DB_BANK1 = 1'b1
    } db_bank_sel_t;

endpackage : db_pkg

// ==== include/db_defines.svh ====
`ifndef DB_DEFINES_SVH
`define DB_DEFINES_SVH

// Table key width, 64 entries
`define DB_KEY_WID 6

// Stored value width
`define DB_VALUE_WID 16

// Open transactions tracked by each context FIFO
`define DB_CTX_DEPTH 4

// Cycles from acceptance to ack in a table bank
`define DB_BANK_LAT 2

`endif
